//--- rtl/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define XLEN 64
`define NUM_REGS 32

// implemented machine CSRs
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341

// wishbone address bit 12 picks the CSR bank
`define WB_CSR_SEL 12

// instruction fields
`define OPCODE_FIELD 6:0
`define RD_FIELD 11:7
`define FUNCT3_FIELD 14:12
`define RS1_FIELD 19:15
`define RS2_FIELD 24:20
`define FUNCT7_FIELD 31:25
`define CSR_FIELD 31:20

`endif

//--- rtl/decodePkg.sv
`include "decode_defines.svh"

package decodePkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] regAddr_t;
    typedef logic [11:0] csrAddr_t;
    typedef logic [31:0] instr_t;

    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_AUIPC     = 7'b0010111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_LUI       = 7'b0110111,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADDW, SUBW, SLLW, SRLW, SRAW, ADDIW, SLLIW, SRLIW, SRAIW,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR, LUI, AUIPC,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, UNKNOWN
    } decodeOp_e;

    // standard mcause numbers
    typedef enum logic [3:0] {
        INVALID_INSTR = 4'd2,
        ECALL_FROM_U  = 4'd8,
        ECALL_FROM_S  = 4'd9,
        ECALL_FROM_M  = 4'd11
    } excCause_e;

    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } privMode_e;

    typedef struct packed {
        logic      valid;
        excCause_e code;
        word_t     value;
    } excData_t;

    typedef struct packed {
        word_t    pc;
        instr_t   instr;
        excData_t exData;
    } fetchData_t;

    typedef struct packed {
        decodeOp_e op;
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        logic      csrWrite;
    } decodeCtl_t;

    typedef struct packed {
        word_t      pc;
        instr_t     instr;
        regAddr_t   ra1;
        regAddr_t   ra2;
        regAddr_t   rd;
        word_t      srcA;
        word_t      srcB;
        word_t      csrA;
        word_t      csrB;
        word_t      imm;
        word_t      pcData;
        word_t      memData;
        decodeCtl_t ctl;
        excData_t   exData;
    } decodeData_t;

endpackage

//--- rtl/decoder.sv
`include "decode_defines.svh"

module decoder import decodePkg::*; (
    input  instr_t     instr,
    output decodeCtl_t ctl
);

    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decodeOp_e op;

    assign opcode = opcode_e'(instr[`OPCODE_FIELD]);
    assign funct3 = instr[`FUNCT3_FIELD];
    assign funct7 = instr[`FUNCT7_FIELD];

    always_comb begin
        op = UNKNOWN;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'h0}: op = ADD;
                    {7'h20, 3'h0}: op = SUB;
                    {7'h00, 3'h1}: op = SLL;
                    {7'h00, 3'h2}: op = SLT;
                    {7'h00, 3'h3}: op = SLTU;
                    {7'h00, 3'h4}: op = XOR;
                    {7'h00, 3'h5}: op = SRL;
                    {7'h20, 3'h5}: op = SRA;
                    {7'h00, 3'h6}: op = OR;
                    {7'h00, 3'h7}: op = AND;
                    default: op = UNKNOWN;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'h0: op = ADDI;
                    3'h2: op = SLTI;
                    3'h3: op = SLTIU;
                    3'h4: op = XORI;
                    3'h6: op = ORI;
                    3'h7: op = ANDI;
                    // rv64 shifts carry a 6 bit shamt
                    3'h1: op = (funct7[6:1] == 6'h00) ? SLLI : UNKNOWN;
                    3'h5: op = (funct7[6:1] == 6'h00) ? SRLI :
                               (funct7[6:1] == 6'h10) ? SRAI : UNKNOWN;
                    default: op = UNKNOWN;
                endcase
            end
            OPC_OP_IMM_32: begin
                case ({funct7, funct3})
                    {7'h00, 3'h1}: op = SLLIW;
                    {7'h00, 3'h5}: op = SRLIW;
                    {7'h20, 3'h5}: op = SRAIW;
                    default: op = (funct3 == 3'h0) ? ADDIW : UNKNOWN;
                endcase
            end
            OPC_OP_32: begin
                case ({funct7, funct3})
                    {7'h00, 3'h0}: op = ADDW;
                    {7'h20, 3'h0}: op = SUBW;
                    {7'h00, 3'h1}: op = SLLW;
                    {7'h00, 3'h5}: op = SRLW;
                    {7'h20, 3'h5}: op = SRAW;
                    default: op = UNKNOWN;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'h0: op = LB;
                    3'h1: op = LH;
                    3'h2: op = LW;
                    3'h3: op = LD;
                    3'h4: op = LBU;
                    3'h5: op = LHU;
                    3'h6: op = LWU;
                    default: op = UNKNOWN;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'h0: op = SB;
                    3'h1: op = SH;
                    3'h2: op = SW;
                    3'h3: op = SD;
                    default: op = UNKNOWN;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'h0: op = BEQ;
                    3'h1: op = BNE;
                    3'h4: op = BLT;
                    3'h5: op = BGE;
                    3'h6: op = BLTU;
                    3'h7: op = BGEU;
                    default: op = UNKNOWN;
                endcase
            end
            OPC_JAL: op = JAL;
            OPC_JALR: op = (funct3 == 3'h0) ? JALR : UNKNOWN;
            OPC_LUI: op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_SYSTEM: begin
                case (funct3)
                    3'h0: op = (instr == 32'h0000_0073) ? ECALL : UNKNOWN;
                    3'h1: op = CSRRW;
                    3'h2: op = CSRRS;
                    3'h3: op = CSRRC;
                    3'h5: op = CSRRWI;
                    3'h6: op = CSRRSI;
                    3'h7: op = CSRRCI;
                    default: op = UNKNOWN;
                endcase
            end
            default: op = UNKNOWN;
        endcase
    end

    // flags follow from the op alone
    always_comb begin
        ctl = '0;
        ctl.op = op;
        case (op)
            LB, LH, LW, LD, LBU, LHU, LWU: begin
                ctl.regWrite = 1'b1;
                ctl.memRead = 1'b1;
            end
            SB, SH, SW, SD: ctl.memWrite = 1'b1;
            BEQ, BNE, BLT, BGE, BLTU, BGEU: ctl.branch = 1'b1;
            JAL, JALR: begin
                ctl.regWrite = 1'b1;
                ctl.jump = 1'b1;
            end
            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: begin
                ctl.regWrite = 1'b1;
                ctl.csrWrite = 1'b1;
            end
            ECALL, UNKNOWN: ctl.regWrite = 1'b0;
            default: ctl.regWrite = 1'b1;
        endcase
    end

endmodule

//--- rtl/immExtend.sv
`include "decode_defines.svh"

module immExtend import decodePkg::*; (
    input  instr_t    instr,
    input  decodeOp_e op,
    output word_t     immOut
);

    always_comb begin
        case (op)
            ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
            ADDIW, SLLIW, SRLIW, SRAIW,
            LB, LH, LW, LD, LBU, LHU, LWU, JALR:
                immOut = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            SB, SH, SW, SD:
                immOut = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            BEQ, BNE, BLT, BGE, BLTU, BGEU:
                immOut = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            LUI, AUIPC:
                immOut = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            JAL:
                immOut = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            // uimm sits in the rs1 slot
            CSRRWI, CSRRSI, CSRRCI:
                immOut = {{(`XLEN-5){1'b0}}, instr[`RS1_FIELD]};
            default:
                immOut = '0;
        endcase
    end

endmodule

//--- rtl/operandSelect.sv
`include "decode_defines.svh"

module operandSelect import decodePkg::*; (
    input  word_t     pc,
    input  decodeOp_e op,
    input  word_t     rd1,
    input  word_t     rd2,
    input  word_t     imm,
    input  word_t     csrVal,
    output word_t     srcA,
    output word_t     srcB,
    output word_t     csrB
);

    always_comb begin
        case (op)
            AUIPC, JAL, BEQ, BNE, BLT, BGE, BLTU, BGEU: srcA = pc;
            LUI: srcA = '0;
            default: srcA = rd1;
        endcase
    end

    always_comb begin
        case (op)
            ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
            ADDIW, SLLIW, SRLIW, SRAIW,
            LB, LH, LW, LD, LBU, LHU, LWU,
            SB, SH, SW, SD, LUI, AUIPC: srcB = imm;
            // link address is base plus 4
            JAL, JALR: srcB = `XLEN'(4);
            default: srcB = rd2;
        endcase
    end

    // other ops write the CSR back unchanged
    always_comb begin
        case (op)
            CSRRW, CSRRS, CSRRC: csrB = rd1;
            CSRRWI, CSRRSI, CSRRCI: csrB = imm;
            default: csrB = csrVal;
        endcase
    end

endmodule

//--- rtl/archState.sv
`include "decode_defines.svh"

module archState import decodePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  regAddr_t             ra1,
    input  regAddr_t             ra2,
    input  csrAddr_t             csrAddr,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [`WB_CSR_SEL:0] wbAdr,
    input  word_t                wbDatW,
    output word_t                rd1,
    output word_t                rd2,
    output word_t                csrVal,
    output word_t                wbDatR,
    output logic                 wbAck
);

    word_t regs [1:`NUM_REGS-1];
    word_t mstatus;
    word_t mtvec;
    word_t mepc;
    word_t mscratch;
    logic wbReq;
    logic wbCsr;
    regAddr_t wbReg;
    csrAddr_t wbCsrAddr;

    function automatic word_t readReg(input regAddr_t a);
        return (a == '0) ? '0 : regs[a];
    endfunction

    function automatic word_t readCsr(input csrAddr_t a);
        case (a)
            `CSR_MSTATUS: return mstatus;
            `CSR_MTVEC: return mtvec;
            `CSR_MEPC: return mepc;
            `CSR_MSCRATCH: return mscratch;
            default: return '0;
        endcase
    endfunction

    // !wbAck keeps a held strobe from counting twice
    assign wbReq = wbCyc && wbStb && !wbAck;
    assign wbCsr = wbAdr[`WB_CSR_SEL];
    assign wbReg = wbAdr[$bits(regAddr_t)-1:0];
    assign wbCsrAddr = wbAdr[11:0];

    assign rd1 = readReg(ra1);
    assign rd2 = readReg(ra2);
    assign csrVal = readCsr(csrAddr);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wbReq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mstatus <= '0;
            mtvec <= '0;
            mepc <= '0;
            mscratch <= '0;
        end else if (wbReq && wbWe && wbCsr) begin
            case (wbCsrAddr)
                `CSR_MSTATUS: mstatus <= wbDatW;
                `CSR_MTVEC: mtvec <= wbDatW;
                `CSR_MEPC: mepc <= wbDatW;
                `CSR_MSCRATCH: mscratch <= wbDatW;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wbReq && wbWe && !wbCsr && wbReg != '0) begin
            regs[wbReg] <= wbDatW;
        end
        if (wbReq) begin
            wbDatR <= wbCsr ? readCsr(wbCsrAddr) : readReg(wbReg);
        end
    end

    ackOnePulse: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |=> !wbAck);

    ackNeedsStrobe: assert property (@(posedge clk) disable iff (!rstN)
        $rose(wbAck) |-> $past(wbCyc && wbStb));

endmodule

//--- rtl/decodeStage.sv
`include "decode_defines.svh"

module decodeStage import decodePkg::*; (
    input  fetchData_t  dataF,
    input  word_t       rd1,
    input  word_t       rd2,
    input  word_t       csrVal,
    input  privMode_e   privMode,
    output regAddr_t    ra1,
    output regAddr_t    ra2,
    output csrAddr_t    csrAddr,
    output decodeData_t dataD
);

    decodeCtl_t ctl;
    word_t imm;
    word_t srcA;
    word_t srcB;
    word_t csrB;
    excData_t exc;
    logic isStore;

    decoder uDecoder (
        .instr(dataF.instr),
        .ctl  (ctl)
    );

    immExtend uImmExtend (
        .instr (dataF.instr),
        .op    (ctl.op),
        .immOut(imm)
    );

    operandSelect uOperandSelect (
        .pc    (dataF.pc),
        .op    (ctl.op),
        .rd1   (rd1),
        .rd2   (rd2),
        .imm   (imm),
        .csrVal(csrVal),
        .srcA  (srcA),
        .srcB  (srcB),
        .csrB  (csrB)
    );

    assign ra1 = dataF.instr[`RS1_FIELD];
    assign ra2 = dataF.instr[`RS2_FIELD];
    assign csrAddr = dataF.instr[`CSR_FIELD];
    assign isStore = ctl.op inside {SB, SH, SW, SD};

    always_comb begin
        exc = '0;
        if (ctl.op == UNKNOWN) begin
            exc.valid = 1'b1;
            exc.code = INVALID_INSTR;
            exc.value = dataF.pc;
        end else if (ctl.op == ECALL) begin
            exc.valid = 1'b1;
            case (privMode)
                U_MODE: exc.code = ECALL_FROM_U;
                S_MODE: exc.code = ECALL_FROM_S;
                default: exc.code = ECALL_FROM_M;
            endcase
        end
    end

    assign dataD.pc = dataF.pc;
    assign dataD.instr = dataF.instr;
    assign dataD.ra1 = ra1;
    assign dataD.ra2 = ra2;
    assign dataD.rd = dataF.instr[`RD_FIELD];
    assign dataD.srcA = srcA;
    assign dataD.srcB = srcB;
    assign dataD.csrA = csrVal;
    assign dataD.csrB = csrB;
    assign dataD.imm = imm;
    // jump base only for jalr
    assign dataD.pcData = (ctl.op == JALR) ? rd1 : '0;
    assign dataD.memData = isStore ? rd2 : '0;
    // an earlier fault wins and kills the instruction
    assign dataD.ctl = dataF.exData.valid ? '0 : ctl;
    assign dataD.exData = dataF.exData.valid ? dataF.exData : exc;

endmodule

//--- rtl/decodeTop.sv
`include "decode_defines.svh"

module decodeTop import decodePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 fetchValid,
    input  fetchData_t           fetchData,
    input  logic                 stall,
    input  privMode_e            privMode,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [`WB_CSR_SEL:0] wbAdr,
    input  word_t                wbDatW,
    output word_t                wbDatR,
    output logic                 wbAck,
    output logic                 decodeValid,
    output decodeData_t          decodeOut
);

    logic fetchValidQ;
    fetchData_t fetchQ;
    decodeData_t dataD;
    regAddr_t ra1;
    regAddr_t ra2;
    csrAddr_t csrAddr;
    word_t rd1;
    word_t rd2;
    word_t csrVal;

    // both stages advance together
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchValidQ <= 1'b0;
            fetchQ <= '0;
            decodeValid <= 1'b0;
            decodeOut <= '0;
        end else if (!stall) begin
            fetchValidQ <= fetchValid;
            fetchQ <= fetchData;
            decodeValid <= fetchValidQ;
            decodeOut <= dataD;
        end
    end

    decodeStage uDecodeStage (
        .dataF   (fetchQ),
        .rd1     (rd1),
        .rd2     (rd2),
        .csrVal  (csrVal),
        .privMode(privMode),
        .ra1     (ra1),
        .ra2     (ra2),
        .csrAddr (csrAddr),
        .dataD   (dataD)
    );

    archState uArchState (
        .clk    (clk),
        .rstN   (rstN),
        .ra1    (ra1),
        .ra2    (ra2),
        .csrAddr(csrAddr),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .rd1    (rd1),
        .rd2    (rd2),
        .csrVal (csrVal),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    outHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
        (rstN && stall) |=> ($stable(decodeOut) && $stable(decodeValid)));

endmodule

//--- tb/decodeChecker.sv
`include "decode_defines.svh"

module decodeChecker import decodePkg::*; (
    input logic        clk,
    input logic        rstN,
    input logic        stall,
    input logic        fetchValid,
    input logic        decodeValid,
    input decodeData_t decodeOut
);

    decodeData_t expQ[$];
    int passCount = 0;
    int failCount = 0;
    int errorCount = 0;
    int recNo = 0;
    // pipeline moved on the last edge
    logic adv = 1'b0;
    // two stage model of the valid bits
    logic [1:0] validPipe = 2'b00;

    function void pushExpected(input decodeData_t e);
        expQ.push_back(e);
    endfunction

    function int pendingCount();
        return expQ.size();
    endfunction

    function void reportError(input string msg);
        $display("%s", msg);
        errorCount++;
    endfunction

    function automatic bit compareField(input string name, input logic [63:0] expV,
                                        input logic [63:0] actV);
        if (expV !== actV) begin
            $display("Fail %0t %s expected %h got %h", $time, name, expV, actV);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function void checkRead(input logic [`WB_CSR_SEL:0] adr, input word_t expV,
                            input word_t actV);
        recNo++;
        if (compareField("wbDatR", expV, actV)) begin
            passCount++;
            $display("record %0d ok, readback of %h", recNo, adr);
        end else begin
            failCount++;
            $display("record %0d failed, readback of %h", recNo, adr);
        end
    endfunction

    always @(posedge clk) begin
        adv <= rstN && !stall;
        if (!rstN) begin
            validPipe <= 2'b00;
        end else if (!stall) begin
            validPipe <= {validPipe[0], fetchValid};
        end
    end

    always @(negedge clk) begin : checkResult
        decodeData_t e;
        bit ok;
        if (rstN) begin
            if (!compareField("decodeValid", 64'(validPipe[1]), 64'(decodeValid))) begin
                failCount++;
            end
        end
        if (adv && decodeValid) begin
            if (expQ.size() == 0) begin
                $display("result at %0t arrived with no record waiting for it", $time);
                errorCount++;
            end else begin
                e = expQ.pop_front();
                ok = 1'b1;
                ok &= compareField("pc", e.pc, decodeOut.pc);
                ok &= compareField("instr", 64'(e.instr), 64'(decodeOut.instr));
                ok &= compareField("rd", 64'(e.rd), 64'(decodeOut.rd));
                ok &= compareField("ra1", 64'(e.ra1), 64'(decodeOut.ra1));
                ok &= compareField("ra2", 64'(e.ra2), 64'(decodeOut.ra2));
                ok &= compareField("op", 64'(e.ctl.op), 64'(decodeOut.ctl.op));
                ok &= compareField("srcA", e.srcA, decodeOut.srcA);
                ok &= compareField("srcB", e.srcB, decodeOut.srcB);
                ok &= compareField("imm", e.imm, decodeOut.imm);
                ok &= compareField("pcData", e.pcData, decodeOut.pcData);
                ok &= compareField("memData", e.memData, decodeOut.memData);
                ok &= compareField("csrA", e.csrA, decodeOut.csrA);
                ok &= compareField("csrB", e.csrB, decodeOut.csrB);
                ok &= compareField("exc valid", 64'(e.exData.valid),
                                   64'(decodeOut.exData.valid));
                ok &= compareField("exc code", 64'(e.exData.code), 64'(decodeOut.exData.code));
                ok &= compareField("exc value", e.exData.value, decodeOut.exData.value);
                // a trapping instruction carries no side effects
                if (e.exData.valid) begin
                    ok &= compareField("ctl flags", 64'(0),
                                       64'({decodeOut.ctl.regWrite, decodeOut.ctl.memRead,
                                            decodeOut.ctl.memWrite, decodeOut.ctl.branch,
                                            decodeOut.ctl.jump, decodeOut.ctl.csrWrite}));
                end
                recNo++;
                if (ok) begin
                    passCount++;
                    $display("record %0d ok, op %s", recNo, e.ctl.op.name());
                end else begin
                    failCount++;
                    $display("record %0d failed, op %s", recNo, e.ctl.op.name());
                end
            end
        end
    end

endmodule

//--- tb/decodeTb.sv
`include "decode_defines.svh"

module decodeTb import decodePkg::*; ();

    logic clk;
    logic rstN;
    logic fetchValid;
    fetchData_t fetchData;
    logic stall;
    privMode_e privMode;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [`WB_CSR_SEL:0] wbAdr;
    word_t wbDatW;
    word_t wbDatR;
    logic wbAck;
    logic decodeValid;
    decodeData_t decodeOut;

    string lines[$];
    int limit = 1000;
    int cycles = 0;
    logic [7:0] lfsr = 8'd92;
    bit loaded;

    decodeTop dut (
        .clk        (clk),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .fetchData  (fetchData),
        .stall      (stall),
        .privMode   (privMode),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatW     (wbDatW),
        .wbDatR     (wbDatR),
        .wbAck      (wbAck),
        .decodeValid(decodeValid),
        .decodeOut  (decodeOut)
    );

    decodeChecker chk (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .fetchValid (fetchValid),
        .decodeValid(decodeValid),
        .decodeOut  (decodeOut)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("run stopped: no finish after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic drawBits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // x0 and unimplemented CSRs drop the write and read zero
    function automatic word_t readbackValue(input logic [63:0] adr, input word_t dat);
        logic [11:0] csr;
        word_t result;
        csr = adr[11:0];
        if (adr[`WB_CSR_SEL]) begin
            if (csr == `CSR_MSTATUS || csr == `CSR_MTVEC || csr == `CSR_MEPC
                    || csr == `CSR_MSCRATCH) begin
                result = dat;
            end else begin
                result = '0;
            end
        end else begin
            result = (adr[4:0] == 5'd0) ? '0 : dat;
        end
        return result;
    endfunction

    task automatic loadPatterns(output bit ok);
        int fd;
        int n;
        string line;
        fd = $fopen("tb/decode_patterns.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && (line.getc(0) == "W" || line.getc(0) == "I")) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            limit = lines.size() * 8 + 20;
        end
    endtask

    // empties both pipeline registers
    task automatic drainPipe(input int n);
        fetchValid = 1'b0;
        stall = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic wbWrite(input logic [63:0] adr, input logic [63:0] dat);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = adr[`WB_CSR_SEL:0];
        wbDatW = dat;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbRead(input logic [63:0] adr, output word_t dat);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = adr[`WB_CSR_SEL:0];
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        dat = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic sendInstr(input logic [63:0] v [0:16]);
        decodeData_t e;
        int gap;
        if (privMode_e'(v[4][1:0]) != privMode) begin
            drainPipe(2);
            privMode = privMode_e'(v[4][1:0]);
        end
        e = '0;
        e.pc = v[0];
        e.instr = v[1][31:0];
        e.rd = v[1][11:7];
        e.ra1 = v[1][19:15];
        e.ra2 = v[1][24:20];
        e.ctl.op = decodeOp_e'(v[6][5:0]);
        e.srcA = v[7];
        e.srcB = v[8];
        e.imm = v[9];
        e.pcData = v[10];
        e.memData = v[11];
        e.csrA = v[12];
        e.csrB = v[13];
        e.exData.valid = v[14][0];
        e.exData.code = excCause_e'(v[15][3:0]);
        e.exData.value = v[16];
        chk.pushExpected(e);
        fetchData.pc = v[0];
        fetchData.instr = v[1][31:0];
        fetchData.exData.valid = v[2][0];
        fetchData.exData.code = excCause_e'(v[3][3:0]);
        fetchData.exData.value = v[0];
        fetchValid = 1'b1;
        stall = 1'b0;
        @(negedge clk);
        fetchValid = 1'b0;
        drawBits(2, gap);
        gap = gap + int'(v[5][0]);
        repeat (gap) begin
            stall = 1'b1;
            @(negedge clk);
        end
        stall = 1'b0;
    endtask

    task automatic runRecord(input string line);
        byte kind;
        int n;
        word_t rdat;
        logic [63:0] v [0:16];
        kind = line.getc(0);
        if (kind == "W") begin
            n = $sscanf(line, "%c %h %h", kind, v[0], v[1]);
            if (n != 3) begin
                chk.reportError("write record is missing fields");
            end
            drainPipe(2);
            wbWrite(v[0], v[1]);
            // bus idle for a cycle between transfers
            @(negedge clk);
            wbRead(v[0], rdat);
            chk.checkRead(v[0][`WB_CSR_SEL:0], readbackValue(v[0], v[1]), rdat);
        end else begin
            n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        kind, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                        v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
            if (n != 18) begin
                chk.reportError("instruction record is missing fields");
            end
            sendInstr(v);
        end
    endtask

    task automatic finishRun(input bit ok);
        if (!ok) begin
            $display("pattern file tb/decode_patterns.txt could not be opened");
        end
        if (chk.pendingCount() > 0) begin
            $display("%0d expected results never came out", chk.pendingCount());
        end
        $display("results: %0d passed, %0d failed, %0d other errors",
                 chk.passCount, chk.failCount, chk.errorCount);
        if (ok && chk.failCount == 0 && chk.errorCount == 0 && chk.pendingCount() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        rstN = 1'b0;
        fetchValid = 1'b0;
        fetchData = '0;
        stall = 1'b0;
        privMode = M_MODE;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        loadPatterns(loaded);
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        if (loaded) begin
            foreach (lines[i]) begin
                runRecord(lines[i]);
            end
            drainPipe(3);
        end
        finishRun(loaded);
    end

endmodule

//--- tb/decode_patterns.txt
# W wbAdr data   (wbAdr bit 12 set selects the CSR bank)
# I pc instr fExc fCause mode stall op srcA srcB imm pcData memData csrA csrB exc code value
W 0001 0000000000000011
W 0002 FFFFFFFFFFFFFFF0
W 0000 00000000DEADBEEF
W 0003 0000000080000000
W 0005 0000000000000555
W 001F 7777777777777777
I 1000 002082B3 0 0 3 0 00 11 FFFFFFFFFFFFFFF0 0 0 0 0 0 0 0 0
I 1004 40100333 0 0 3 0 01 0 11 0 0 0 0 0 0 0 0
I 1008 FFB08393 0 0 3 1 0A 11 FFFFFFFFFFFFFFFB FFFFFFFFFFFFFFFB 0 0 0 0 0 0 0
I 100C 40315413 0 0 3 0 12 FFFFFFFFFFFFFFF0 403 403 0 0 0 0 0 0 0
I 1010 001184BB 0 0 3 0 13 80000000 11 0 0 0 0 0 0 0 0
I 1014 FF813503 0 0 3 0 1F FFFFFFFFFFFFFFF0 FFFFFFFFFFFFFFF8 FFFFFFFFFFFFFFF8 0 0 0 0 0 0 0
I 1018 00113823 0 0 3 0 26 FFFFFFFFFFFFFFF0 10 10 0 11 0 0 0 0 0
I 101C FE2098E3 0 0 3 1 28 101C FFFFFFFFFFFFFFF0 FFFFFFFFFFFFFFF0 0 0 0 0 0 0 0
I 1020 0010006F 0 0 3 0 2D 1020 4 800 0 0 0 0 0 0 0
I 1024 00C18067 0 0 3 0 2E 80000000 4 C 80000000 0 0 0 0 0 0
I 1028 800005B7 0 0 3 0 2F 0 FFFFFFFF80000000 FFFFFFFF80000000 0 0 0 0 0 0 0
I 102C 00001617 0 0 3 0 30 102C 1000 1000 0 0 0 0 0 0 0
W 1300 0000000000001888
W 1340 00000000CAFEF00D
W 1305 0000000000000100
W 1341 0000000000002000
W 17C0 0000000000001234
I 1030 340096F3 0 0 3 0 31 11 0 0 0 0 CAFEF00D 11 0 0 0
I 1034 3002E773 0 0 3 0 35 555 0 5 0 0 1888 5 0 0 0
I 1038 7C0137F3 0 0 3 1 33 FFFFFFFFFFFFFFF0 0 0 0 0 0 FFFFFFFFFFFFFFF0 0 0 0
I 103C 30502873 0 0 3 0 32 0 555 0 0 0 100 0 0 0 0
I 1040 FFFFFFFF 0 0 3 0 38 7777777777777777 7777777777777777 0 0 0 0 0 1 2 1040
I 1044 00000073 0 0 0 0 37 0 0 0 0 0 0 0 1 8 0
I 1048 00000073 0 0 1 0 37 0 0 0 0 0 0 0 1 9 0
I 104C 00000073 0 0 3 0 37 0 0 0 0 0 0 0 1 B 0
I 1050 00000013 1 2 3 0 00 0 0 0 0 0 0 0 1 2 1050

//--- project.f
+incdir+rtl
rtl/decodePkg.sv
rtl/decoder.sv
rtl/immExtend.sv
rtl/operandSelect.sv
rtl/archState.sv
rtl/decodeStage.sv
rtl/decodeTop.sv
tb/decodeChecker.sv
tb/decodeTb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := decodeTb
FILELIST := project.f
LOG      := sim.log
BIN      := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
